/* compile.f */
logic/isa_pkg.sv
logic/queue_pkg.sv
logic/issue_queue.sv
logic/pair_check.sv
logic/reg_file.sv
logic/issue_register.sv
logic/issue_stage.sv
tests/issue_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module issue_stage_tb -f compile.f

output=$(./obj_dir/Vissue_stage_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi

/* tests/issue_stage_tb.sv */
`timescale 1ns/1ps

module issue_stage_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_CYCLES  = 600;
    localparam int FILL_CYCLES    = 10;
    localparam int FLUSH_CYCLES   = 11;
    localparam int DRAIN_BUDGET   = 20;
    localparam int STIM_CYCLES    = RESET_CYCLES + RANDOM_CYCLES + FILL_CYCLES +
                                    FLUSH_CYCLES + 4 * DRAIN_BUDGET;
    localparam int TIMEOUT_CYCLES = 3 * STIM_CYCLES;

    typedef struct packed {
        isa_pkg::ctl_t      ctl;
        isa_pkg::reg_addr_t dest;
        isa_pkg::reg_addr_t srca;
        isa_pkg::reg_addr_t srcb;
        isa_pkg::word_t     pc;
    } entry_t;

    logic               clk = 1'b0;
    logic               reset;
    logic               stall;
    logic               flush;
    logic               in_a_valid;
    logic               in_b_valid;
    isa_pkg::ctl_t      in_a_ctl;
    isa_pkg::ctl_t      in_b_ctl;
    isa_pkg::reg_addr_t in_a_dest;
    isa_pkg::reg_addr_t in_a_srca;
    isa_pkg::reg_addr_t in_a_srcb;
    isa_pkg::reg_addr_t in_b_dest;
    isa_pkg::reg_addr_t in_b_srca;
    isa_pkg::reg_addr_t in_b_srcb;
    isa_pkg::word_t     in_a_pc;
    isa_pkg::word_t     in_b_pc;
    logic               wb_a_en;
    logic               wb_b_en;
    isa_pkg::reg_addr_t wb_a_addr;
    isa_pkg::reg_addr_t wb_b_addr;
    isa_pkg::word_t     wb_a_data;
    isa_pkg::word_t     wb_b_data;
    logic               queue_full;
    logic               a_valid;
    logic               b_valid;
    isa_pkg::ctl_t      a_ctl;
    isa_pkg::ctl_t      b_ctl;
    isa_pkg::reg_addr_t a_dest;
    isa_pkg::reg_addr_t b_dest;
    isa_pkg::word_t     a_pc;
    isa_pkg::word_t     b_pc;
    isa_pkg::word_t     a_opa;
    isa_pkg::word_t     a_opb;
    isa_pkg::word_t     b_opa;
    isa_pkg::word_t     b_opb;

    // reference state
    entry_t         model_q [$];
    isa_pkg::word_t reg_model [isa_pkg::REG_COUNT];
    logic           exp_a_valid;
    logic           exp_b_valid;
    entry_t         exp_a;
    entry_t         exp_b;
    isa_pkg::word_t exp_a_opa;
    isa_pkg::word_t exp_a_opb;
    isa_pkg::word_t exp_b_opa;
    isa_pkg::word_t exp_b_opb;

    // pair offered by decode and held until accepted
    bit             have_pending;
    bit             pend_a_valid;
    bit             pend_b_valid;
    entry_t         pend_a;
    entry_t         pend_b;

    logic [31:0]    rand_state;
    isa_pkg::word_t pc_next;
    int             error_count;
    int             check_count;
    int             cycle_count;

    issue_stage DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, rand_state[31:16]};
    endfunction

    // mix weighted toward memory, branch, hi/lo and eret hazards
    function automatic isa_pkg::ctl_t random_ctl();
        isa_pkg::ctl_t ctl;
        ctl = '0;
        case (next_rand() % 13)
            0, 1, 2: ctl[isa_pkg::CTL_REGWRITE] = 1'b1;
            3:
            begin
                ctl[isa_pkg::CTL_MEM]      = 1'b1;
                ctl[isa_pkg::CTL_REGWRITE] = 1'b1;
            end
            4: ctl[isa_pkg::CTL_MEM] = 1'b1;
            5: ctl[isa_pkg::CTL_BRANCH] = 1'b1;
            6: ctl[isa_pkg::CTL_HIWRITE] = 1'b1;
            7: ctl[isa_pkg::CTL_LOWRITE] = 1'b1;
            8:
            begin
                ctl[isa_pkg::CTL_HIREAD]   = 1'b1;
                ctl[isa_pkg::CTL_REGWRITE] = 1'b1;
            end
            9:
            begin
                ctl[isa_pkg::CTL_LOREAD]   = 1'b1;
                ctl[isa_pkg::CTL_REGWRITE] = 1'b1;
            end
            10: ctl[isa_pkg::CTL_ERET] = 1'b1;
            default: ctl = '0;
        endcase
        return ctl;
    endfunction

    // few registers so that dependencies show up often
    function automatic entry_t random_entry();
        entry_t e;
        e.ctl   = random_ctl();
        e.dest  = isa_pkg::reg_addr_t'(next_rand() % 4);
        e.srca  = isa_pkg::reg_addr_t'(next_rand() % 4);
        e.srcb  = isa_pkg::reg_addr_t'(next_rand() % 4);
        e.pc    = pc_next;
        pc_next = pc_next + 32'd4;
        return e;
    endfunction

    function automatic bit may_pair(input entry_t a, input entry_t b);
        bit hazard;
        hazard = 1'b0;
        if (a.ctl[isa_pkg::CTL_MEM] && b.ctl[isa_pkg::CTL_MEM])
            hazard = 1'b1;
        if (a.ctl[isa_pkg::CTL_REGWRITE] && a.dest != '0 &&
            (a.dest == b.srca || a.dest == b.srcb))
            hazard = 1'b1;
        if (a.ctl[isa_pkg::CTL_HIWRITE] && b.ctl[isa_pkg::CTL_HIREAD])
            hazard = 1'b1;
        if (a.ctl[isa_pkg::CTL_LOWRITE] && b.ctl[isa_pkg::CTL_LOREAD])
            hazard = 1'b1;
        if (b.ctl[isa_pkg::CTL_BRANCH])
            hazard = 1'b1;
        if (a.ctl[isa_pkg::CTL_ERET] || b.ctl[isa_pkg::CTL_ERET])
            hazard = 1'b1;
        return !hazard;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        assert (got === expected)
        else
        begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_outputs();
        check_value("a_valid", 32'(a_valid), 32'(exp_a_valid));
        check_value("a_ctl", 32'(a_ctl), 32'(exp_a.ctl));
        check_value("a_dest", 32'(a_dest), 32'(exp_a.dest));
        check_value("a_pc", a_pc, exp_a.pc);
        check_value("a_opa", a_opa, exp_a_opa);
        check_value("a_opb", a_opb, exp_a_opb);
        check_value("b_valid", 32'(b_valid), 32'(exp_b_valid));
        check_value("b_ctl", 32'(b_ctl), 32'(exp_b.ctl));
        check_value("b_dest", 32'(b_dest), 32'(exp_b.dest));
        check_value("b_pc", b_pc, exp_b.pc);
        check_value("b_opa", b_opa, exp_b_opa);
        check_value("b_opb", b_opb, exp_b_opb);
    endtask

    task automatic clear_expected();
        exp_a_valid = 1'b0;
        exp_b_valid = 1'b0;
        exp_a       = '0;
        exp_b       = '0;
        exp_a_opa   = '0;
        exp_a_opb   = '0;
        exp_b_opa   = '0;
        exp_b_opb   = '0;
    endtask

    task automatic make_pair(input int offer_pct, input bit filler);
        if (filler)
        begin
            // plain single instruction that fills a branch delay slot
            pend_a_valid = 1'b1;
            pend_b_valid = 1'b0;
            pend_a       = '0;
            pend_a.pc    = pc_next;
            pc_next      = pc_next + 32'd4;
        end
        else
        begin
            pend_a_valid = (next_rand() % 100) < offer_pct;
            pend_b_valid = (next_rand() % 100) < offer_pct;
            pend_a       = random_entry();
            pend_b       = random_entry();
        end
        have_pending = 1'b1;
    endtask

    // each call checks the last edge, drives new inputs and predicts the next edge
    task automatic step_cycle(input logic stall_in, input logic flush_in,
                              input int offer_pct, input bit filler);
        bit drive;
        bit full_exp;
        bit issue_a_exp;
        bit issue_b_exp;
        int need;
        int free;
        @(negedge clk);
        compare_outputs();
        drive = (offer_pct > 0) || filler;
        if (drive && !have_pending)
            make_pair(offer_pct, filler);
        stall      = stall_in;
        flush      = flush_in;
        in_a_valid = drive && pend_a_valid;
        in_b_valid = drive && pend_b_valid;
        in_a_ctl   = pend_a.ctl;
        in_a_dest  = pend_a.dest;
        in_a_srca  = pend_a.srca;
        in_a_srcb  = pend_a.srcb;
        in_a_pc    = pend_a.pc;
        in_b_ctl   = pend_b.ctl;
        in_b_dest  = pend_b.dest;
        in_b_srca  = pend_b.srca;
        in_b_srcb  = pend_b.srcb;
        in_b_pc    = pend_b.pc;
        wb_a_en    = (next_rand() % 2) == 1;
        wb_a_addr  = isa_pkg::reg_addr_t'(next_rand() % 4);
        wb_a_data  = (next_rand() << 16) | next_rand();
        wb_b_en    = (next_rand() % 2) == 1;
        wb_b_addr  = isa_pkg::reg_addr_t'(next_rand() % 4);
        wb_b_data  = (next_rand() << 16) | next_rand();

        need     = int'(in_a_valid) + int'(in_b_valid);
        free     = queue_pkg::ISSUE_QUEUE_SIZE - model_q.size();
        full_exp = need > free;
        #1;
        check_value("queue_full", 32'(queue_full), 32'(full_exp));

        if (flush_in)
        begin
            model_q.delete();
            clear_expected();
        end
        else
        begin
            if (!stall_in)
            begin
                issue_a_exp = model_q.size() > 0;
                issue_b_exp = 1'b0;
                if (issue_a_exp && model_q[0].ctl[isa_pkg::CTL_BRANCH] && model_q.size() < 2)
                    issue_a_exp = 1'b0;
                if (issue_a_exp && model_q.size() > 1)
                    issue_b_exp = may_pair(model_q[0], model_q[1]);
                clear_expected();
                if (issue_a_exp)
                begin
                    exp_a_valid = 1'b1;
                    exp_a       = model_q[0];
                    exp_a_opa   = reg_model[exp_a.srca];
                    exp_a_opb   = reg_model[exp_a.srcb];
                    void'(model_q.pop_front());
                end
                if (issue_b_exp)
                begin
                    exp_b_valid = 1'b1;
                    exp_b       = model_q[0];
                    exp_b_opa   = reg_model[exp_b.srca];
                    exp_b_opb   = reg_model[exp_b.srcb];
                    void'(model_q.pop_front());
                end
            end
            if (!full_exp)
            begin
                if (in_a_valid)
                    model_q.push_back(pend_a);
                if (in_b_valid)
                    model_q.push_back(pend_b);
            end
        end
        if (drive && (flush_in || !full_exp))
            have_pending = 1'b0;

        // writebacks land at the coming edge with port b last
        if (wb_a_en && wb_a_addr != '0)
            reg_model[wb_a_addr] = wb_a_data;
        if (wb_b_en && wb_b_addr != '0)
            reg_model[wb_b_addr] = wb_b_data;
    endtask

    task automatic drain_queue();
        while (model_q.size() > 0 || exp_a_valid || exp_b_valid)
        begin
            // a lone branch needs its delay slot before it can leave
            if (model_q.size() == 1 && model_q[0].ctl[isa_pkg::CTL_BRANCH])
                step_cycle(1'b0, 1'b0, 0, 1'b1);
            else
                step_cycle(1'b0, 1'b0, 0, 1'b0);
        end
    endtask

    initial
    begin
        logic rnd_stall;
        logic rnd_flush;
        reset        = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        in_a_valid   = 1'b0;
        in_b_valid   = 1'b0;
        in_a_ctl     = '0;
        in_b_ctl     = '0;
        in_a_dest    = '0;
        in_a_srca    = '0;
        in_a_srcb    = '0;
        in_b_dest    = '0;
        in_b_srca    = '0;
        in_b_srcb    = '0;
        in_a_pc      = '0;
        in_b_pc      = '0;
        wb_a_en      = 1'b0;
        wb_b_en      = 1'b0;
        wb_a_addr    = '0;
        wb_b_addr    = '0;
        wb_a_data    = '0;
        wb_b_data    = '0;
        rand_state   = 32'd3309;
        pc_next      = 32'h0000_1000;
        have_pending = 1'b0;
        pend_a       = '0;
        pend_b       = '0;
        error_count  = 0;
        check_count  = 0;
        for (int i = 0; i < isa_pkg::REG_COUNT; i++)
            reg_model[i] = '0;
        clear_expected();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // mixed traffic with occasional stall and flush
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            rnd_stall = (next_rand() % 8) == 0;
            rnd_flush = (next_rand() % 40) == 0;
            step_cycle(rnd_stall, rnd_flush, 60, 1'b0);
        end
        drain_queue();

        // stall held while decode keeps offering pairs, so the queue overflows
        for (int i = 0; i < FILL_CYCLES; i++)
            step_cycle(1'b1, 1'b0, 100, 1'b0);
        drain_queue();

        // flush with a loaded queue and valid outputs
        for (int i = 0; i < 3; i++)
            step_cycle(1'b0, 1'b0, 100, 1'b0);
        for (int i = 0; i < 3; i++)
            step_cycle(1'b1, 1'b0, 100, 1'b0);
        step_cycle(1'b0, 1'b1, 100, 1'b0);
        for (int i = 0; i < 4; i++)
            step_cycle(1'b0, 1'b0, 100, 1'b0);
        drain_queue();
        step_cycle(1'b0, 1'b0, 0, 1'b0);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               flush,
    input  logic               in_a_valid,
    input  logic               in_b_valid,
    input  isa_pkg::ctl_t      in_a_ctl,
    input  isa_pkg::ctl_t      in_b_ctl,
    input  isa_pkg::reg_addr_t in_a_dest,
    input  isa_pkg::reg_addr_t in_a_srca,
    input  isa_pkg::reg_addr_t in_a_srcb,
    input  isa_pkg::reg_addr_t in_b_dest,
    input  isa_pkg::reg_addr_t in_b_srca,
    input  isa_pkg::reg_addr_t in_b_srcb,
    input  isa_pkg::word_t     in_a_pc,
    input  isa_pkg::word_t     in_b_pc,
    input  logic               wb_a_en,
    input  logic               wb_b_en,
    input  isa_pkg::reg_addr_t wb_a_addr,
    input  isa_pkg::reg_addr_t wb_b_addr,
    input  isa_pkg::word_t     wb_a_data,
    input  isa_pkg::word_t     wb_b_data,
    output logic               queue_full,
    output logic               a_valid,
    output logic               b_valid,
    output isa_pkg::ctl_t      a_ctl,
    output isa_pkg::ctl_t      b_ctl,
    output isa_pkg::reg_addr_t a_dest,
    output isa_pkg::reg_addr_t b_dest,
    output isa_pkg::word_t     a_pc,
    output isa_pkg::word_t     b_pc,
    output isa_pkg::word_t     a_opa,
    output isa_pkg::word_t     a_opb,
    output isa_pkg::word_t     b_opa,
    output isa_pkg::word_t     b_opb
);

    logic               head_valid;
    logic               next_valid;
    isa_pkg::ctl_t      head_ctl;
    isa_pkg::ctl_t      next_ctl;
    isa_pkg::reg_addr_t head_dest;
    isa_pkg::reg_addr_t head_srca;
    isa_pkg::reg_addr_t head_srcb;
    isa_pkg::reg_addr_t next_dest;
    isa_pkg::reg_addr_t next_srca;
    isa_pkg::reg_addr_t next_srcb;
    isa_pkg::word_t     head_pc;
    isa_pkg::word_t     next_pc;
    isa_pkg::word_t     head_opa;
    isa_pkg::word_t     head_opb;
    isa_pkg::word_t     next_opa;
    isa_pkg::word_t     next_opb;
    logic               issue_a;
    logic               issue_b;
    logic               pop_one;
    logic               pop_two;

    // stall gating of the pops happens inside the queue
    assign pop_one = issue_a && !issue_b;
    assign pop_two = issue_b;

    issue_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .flush      (flush),
        .pop_one    (pop_one),
        .pop_two    (pop_two),
        .in_a_valid (in_a_valid),
        .in_b_valid (in_b_valid),
        .in_a_ctl   (in_a_ctl),
        .in_b_ctl   (in_b_ctl),
        .in_a_dest  (in_a_dest),
        .in_a_srca  (in_a_srca),
        .in_a_srcb  (in_a_srcb),
        .in_b_dest  (in_b_dest),
        .in_b_srca  (in_b_srca),
        .in_b_srcb  (in_b_srcb),
        .in_a_pc    (in_a_pc),
        .in_b_pc    (in_b_pc),
        .queue_full (queue_full),
        .head_valid (head_valid),
        .next_valid (next_valid),
        .head_ctl   (head_ctl),
        .next_ctl   (next_ctl),
        .head_dest  (head_dest),
        .head_srca  (head_srca),
        .head_srcb  (head_srcb),
        .next_dest  (next_dest),
        .next_srca  (next_srca),
        .next_srcb  (next_srcb),
        .head_pc    (head_pc),
        .next_pc    (next_pc)
    );

    pair_check u_pair (
        .head_valid (head_valid),
        .next_valid (next_valid),
        .head_ctl   (head_ctl),
        .next_ctl   (next_ctl),
        .head_dest  (head_dest),
        .next_srca  (next_srca),
        .next_srcb  (next_srcb),
        .issue_a    (issue_a),
        .issue_b    (issue_b)
    );

    reg_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_a_srca (head_srca),
        .rd_a_srcb (head_srcb),
        .rd_b_srca (next_srca),
        .rd_b_srcb (next_srcb),
        .rd_a_opa  (head_opa),
        .rd_a_opb  (head_opb),
        .rd_b_opa  (next_opa),
        .rd_b_opb  (next_opb),
        .wb_a_en   (wb_a_en),
        .wb_b_en   (wb_b_en),
        .wb_a_addr (wb_a_addr),
        .wb_b_addr (wb_b_addr),
        .wb_a_data (wb_a_data),
        .wb_b_data (wb_b_data)
    );

    issue_register u_out (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .head_ctl  (head_ctl),
        .next_ctl  (next_ctl),
        .head_dest (head_dest),
        .next_dest (next_dest),
        .head_pc   (head_pc),
        .next_pc   (next_pc),
        .head_opa  (head_opa),
        .head_opb  (head_opb),
        .next_opa  (next_opa),
        .next_opb  (next_opb),
        .a_valid   (a_valid),
        .b_valid   (b_valid),
        .a_ctl     (a_ctl),
        .b_ctl     (b_ctl),
        .a_dest    (a_dest),
        .b_dest    (b_dest),
        .a_pc      (a_pc),
        .b_pc      (b_pc),
        .a_opa     (a_opa),
        .a_opb     (a_opb),
        .b_opa     (b_opa),
        .b_opb     (b_opb)
    );

endmodule

/* logic/issue_register.sv */
`timescale 1ns/1ps

module issue_register (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               flush,
    input  logic               issue_a,
    input  logic               issue_b,
    input  isa_pkg::ctl_t      head_ctl,
    input  isa_pkg::ctl_t      next_ctl,
    input  isa_pkg::reg_addr_t head_dest,
    input  isa_pkg::reg_addr_t next_dest,
    input  isa_pkg::word_t     head_pc,
    input  isa_pkg::word_t     next_pc,
    input  isa_pkg::word_t     head_opa,
    input  isa_pkg::word_t     head_opb,
    input  isa_pkg::word_t     next_opa,
    input  isa_pkg::word_t     next_opb,
    output logic               a_valid,
    output logic               b_valid,
    output isa_pkg::ctl_t      a_ctl,
    output isa_pkg::ctl_t      b_ctl,
    output isa_pkg::reg_addr_t a_dest,
    output isa_pkg::reg_addr_t b_dest,
    output isa_pkg::word_t     a_pc,
    output isa_pkg::word_t     b_pc,
    output isa_pkg::word_t     a_opa,
    output isa_pkg::word_t     a_opb,
    output isa_pkg::word_t     b_opa,
    output isa_pkg::word_t     b_opb
);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset || flush)
        begin
            a_valid <= 1'b0;
            a_ctl   <= '0;
            a_dest  <= '0;
            a_pc    <= '0;
            a_opa   <= '0;
            a_opb   <= '0;
        end
        else if (!stall)
        begin
            // an empty slot goes out as zeros
            a_valid <= issue_a;
            a_ctl   <= issue_a ? head_ctl : '0;
            a_dest  <= issue_a ? head_dest : '0;
            a_pc    <= issue_a ? head_pc : '0;
            a_opa   <= issue_a ? head_opa : '0;
            a_opb   <= issue_a ? head_opb : '0;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset || flush)
        begin
            b_valid <= 1'b0;
            b_ctl   <= '0;
            b_dest  <= '0;
            b_pc    <= '0;
            b_opa   <= '0;
            b_opb   <= '0;
        end
        else if (!stall)
        begin
            b_valid <= issue_b;
            b_ctl   <= issue_b ? next_ctl : '0;
            b_dest  <= issue_b ? next_dest : '0;
            b_pc    <= issue_b ? next_pc : '0;
            b_opa   <= issue_b ? next_opa : '0;
            b_opb   <= issue_b ? next_opb : '0;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::reg_addr_t rd_a_srca,
    input  isa_pkg::reg_addr_t rd_a_srcb,
    input  isa_pkg::reg_addr_t rd_b_srca,
    input  isa_pkg::reg_addr_t rd_b_srcb,
    output isa_pkg::word_t     rd_a_opa,
    output isa_pkg::word_t     rd_a_opb,
    output isa_pkg::word_t     rd_b_opa,
    output isa_pkg::word_t     rd_b_opb,
    input  logic               wb_a_en,
    input  logic               wb_b_en,
    input  isa_pkg::reg_addr_t wb_a_addr,
    input  isa_pkg::reg_addr_t wb_b_addr,
    input  isa_pkg::word_t     wb_a_data,
    input  isa_pkg::word_t     wb_b_data
);

    isa_pkg::word_t regs [isa_pkg::REG_COUNT];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < isa_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (wb_a_en && (wb_a_addr != '0))
                regs[wb_a_addr] <= wb_a_data;
            // port b comes last so it wins on the same address
            if (wb_b_en && (wb_b_addr != '0))
                regs[wb_b_addr] <= wb_b_data;
        end
    end

    // reads see the old value until the edge since there is no bypass
    assign rd_a_opa = regs[rd_a_srca];
    assign rd_a_opb = regs[rd_a_srcb];
    assign rd_b_opa = regs[rd_b_srca];
    assign rd_b_opb = regs[rd_b_srcb];

endmodule

/* logic/pair_check.sv */
`timescale 1ns/1ps

module pair_check (
    input  logic               head_valid,
    input  logic               next_valid,
    input  isa_pkg::ctl_t      head_ctl,
    input  isa_pkg::ctl_t      next_ctl,
    input  isa_pkg::reg_addr_t head_dest,
    input  isa_pkg::reg_addr_t next_srca,
    input  isa_pkg::reg_addr_t next_srcb,
    output logic               issue_a,
    output logic               issue_b
);

    logic mem_pair;
    logic raw_reg;
    logic raw_hilo;
    logic branch_a;
    logic branch_b;
    logic eret_any;

    assign mem_pair = head_ctl[isa_pkg::CTL_MEM] && next_ctl[isa_pkg::CTL_MEM];

    // register 0 never carries a dependency
    assign raw_reg = head_ctl[isa_pkg::CTL_REGWRITE] && (head_dest != '0) &&
                     ((head_dest == next_srca) || (head_dest == next_srcb));

    assign raw_hilo = (head_ctl[isa_pkg::CTL_HIWRITE] && next_ctl[isa_pkg::CTL_HIREAD]) ||
                      (head_ctl[isa_pkg::CTL_LOWRITE] && next_ctl[isa_pkg::CTL_LOREAD]);

    assign branch_a = head_ctl[isa_pkg::CTL_BRANCH];
    assign branch_b = next_ctl[isa_pkg::CTL_BRANCH];
    assign eret_any = head_ctl[isa_pkg::CTL_ERET] || next_ctl[isa_pkg::CTL_ERET];

    // a branch holds until its delay slot is in the queue
    assign issue_a = head_valid && !(branch_a && !next_valid);

    assign issue_b = issue_a && next_valid &&
                     !(mem_pair || raw_reg || raw_hilo || branch_b || eret_any);

endmodule

/* logic/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               flush,
    input  logic               pop_one,
    input  logic               pop_two,
    input  logic               in_a_valid,
    input  logic               in_b_valid,
    input  isa_pkg::ctl_t      in_a_ctl,
    input  isa_pkg::ctl_t      in_b_ctl,
    input  isa_pkg::reg_addr_t in_a_dest,
    input  isa_pkg::reg_addr_t in_a_srca,
    input  isa_pkg::reg_addr_t in_a_srcb,
    input  isa_pkg::reg_addr_t in_b_dest,
    input  isa_pkg::reg_addr_t in_b_srca,
    input  isa_pkg::reg_addr_t in_b_srcb,
    input  isa_pkg::word_t     in_a_pc,
    input  isa_pkg::word_t     in_b_pc,
    output logic               queue_full,
    output logic               head_valid,
    output logic               next_valid,
    output isa_pkg::ctl_t      head_ctl,
    output isa_pkg::ctl_t      next_ctl,
    output isa_pkg::reg_addr_t head_dest,
    output isa_pkg::reg_addr_t head_srca,
    output isa_pkg::reg_addr_t head_srcb,
    output isa_pkg::reg_addr_t next_dest,
    output isa_pkg::reg_addr_t next_srca,
    output isa_pkg::reg_addr_t next_srcb,
    output isa_pkg::word_t     head_pc,
    output isa_pkg::word_t     next_pc
);

    logic [queue_pkg::ISSUE_QUEUE_SIZE-1:0] valid;

    isa_pkg::ctl_t      q_ctl  [queue_pkg::ISSUE_QUEUE_SIZE];
    isa_pkg::reg_addr_t q_dest [queue_pkg::ISSUE_QUEUE_SIZE];
    isa_pkg::reg_addr_t q_srca [queue_pkg::ISSUE_QUEUE_SIZE];
    isa_pkg::reg_addr_t q_srcb [queue_pkg::ISSUE_QUEUE_SIZE];
    isa_pkg::word_t     q_pc   [queue_pkg::ISSUE_QUEUE_SIZE];

    queue_pkg::queue_ptr_t head;
    queue_pkg::queue_ptr_t head_plus1;
    queue_pkg::queue_ptr_t head_plus2;
    queue_pkg::queue_ptr_t tail;
    queue_pkg::queue_ptr_t tail_plus1;
    queue_pkg::queue_ptr_t tail_plus2;
    queue_pkg::queue_ptr_t b_slot;

    logic enq;
    logic do_pop_one;
    logic do_pop_two;

    assign head_plus1 = head + queue_pkg::queue_ptr_t'(1);
    assign head_plus2 = head + queue_pkg::queue_ptr_t'(2);
    assign tail_plus1 = tail + queue_pkg::queue_ptr_t'(1);
    assign tail_plus2 = tail + queue_pkg::queue_ptr_t'(2);

    // occupied entries are contiguous, so a valid slot at the tail means no room
    assign queue_full = ((in_a_valid || in_b_valid) && valid[tail]) ||
                        (in_a_valid && in_b_valid && valid[tail_plus1]);

    assign enq        = !flush && !queue_full;
    assign b_slot     = in_a_valid ? tail_plus1 : tail;
    assign do_pop_one = pop_one && !stall;
    assign do_pop_two = pop_two && !stall;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
        end
        else if (flush)
        begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
        end
        else
        begin
            // popped slots are valid and enqueued slots are free, so they never collide
            if (do_pop_two)
            begin
                valid[head]       <= 1'b0;
                valid[head_plus1] <= 1'b0;
                head              <= head_plus2;
            end
            else if (do_pop_one)
            begin
                valid[head] <= 1'b0;
                head        <= head_plus1;
            end
            if (enq)
            begin
                if (in_a_valid)
                    valid[tail] <= 1'b1;
                if (in_b_valid)
                    valid[b_slot] <= 1'b1;
                if (in_a_valid && in_b_valid)
                    tail <= tail_plus2;
                else if (in_a_valid || in_b_valid)
                    tail <= tail_plus1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq && in_a_valid)
        begin
            q_ctl[tail]  <= in_a_ctl;
            q_dest[tail] <= in_a_dest;
            q_srca[tail] <= in_a_srca;
            q_srcb[tail] <= in_a_srcb;
            q_pc[tail]   <= in_a_pc;
        end
        if (enq && in_b_valid)
        begin
            q_ctl[b_slot]  <= in_b_ctl;
            q_dest[b_slot] <= in_b_dest;
            q_srca[b_slot] <= in_b_srca;
            q_srcb[b_slot] <= in_b_srcb;
            q_pc[b_slot]   <= in_b_pc;
        end
    end

    assign head_valid = valid[head];
    assign next_valid = valid[head_plus1];
    assign head_ctl   = q_ctl[head];
    assign head_dest  = q_dest[head];
    assign head_srca  = q_srca[head];
    assign head_srcb  = q_srcb[head];
    assign head_pc    = q_pc[head];
    assign next_ctl   = q_ctl[head_plus1];
    assign next_dest  = q_dest[head_plus1];
    assign next_srca  = q_srca[head_plus1];
    assign next_srcb  = q_srcb[head_plus1];
    assign next_pc    = q_pc[head_plus1];

endmodule

/* logic/queue_pkg.sv */
package queue_pkg;

    // entries in the issue queue
    localparam int ISSUE_QUEUE_SIZE = 8;

    // head and tail pointers wrap at the queue size
    localparam int QUEUE_PTR_WIDTH = 3;

    typedef logic [QUEUE_PTR_WIDTH-1:0] queue_ptr_t;

endpackage

/* logic/isa_pkg.sv */
package isa_pkg;

    // data word or program counter
    typedef logic [31:0] word_t;

    // general register address
    typedef logic [4:0] reg_addr_t;

    // decoded control vector
    typedef logic [7:0] ctl_t;

    // bit positions inside ctl_t
    localparam int CTL_REGWRITE = 0;
    localparam int CTL_MEM      = 1;
    localparam int CTL_BRANCH   = 2;
    localparam int CTL_HIWRITE  = 3;
    localparam int CTL_LOWRITE  = 4;
    localparam int CTL_HIREAD   = 5;
    localparam int CTL_LOREAD   = 6;
    localparam int CTL_ERET     = 7;

    localparam int REG_COUNT = 32;

endpackage
